// File: mipsPkg.sv
package mipsPkg;

    localparam int imWords    = 1024;
    localparam int dmWords    = 1024;
    localparam int imAddrBits = $clog2(imWords);
    localparam int dmAddrBits = $clog2(dmWords);

    localparam logic [31:0] resetPc = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLb    = 6'h20;
    localparam logic [5:0] opLh    = 6'h21;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opLbu   = 6'h24;
    localparam logic [5:0] opSb    = 6'h28;
    localparam logic [5:0] opSh    = 6'h29;
    localparam logic [5:0] opSw    = 6'h2b;

    // funct field of R-type
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmt;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jFmt;

    typedef union packed {
        rFmt rType;
        iFmt iType;
        jFmt jType;
    } instrWord;

    typedef enum logic [2:0] {npcPc4, npcBeq, npcBne, npcJump, npcReg} npcSel;
    typedef enum logic [1:0] {wrRt, wrRd, wrRa} wrSel;
    typedef enum logic [1:0] {wdAlu, wdMem, wdPc4} wdSel;
    typedef enum logic [1:0] {extZero, extSign, extUpper} extSel;
    typedef enum logic {bReg, bImm} bSel;
    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluSrl, aluLui} aluOp;
    typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} memSizeSel;

    typedef struct packed {
        npcSel     npc;
        wrSel      wr;
        wdSel      wd;
        extSel     ext;
        bSel       b;
        aluOp      alu;
        logic      regWe;
        logic      memWe;
        memSizeSel memSize;
        logic      memSigned;
    } ctrlBundle;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
    } commitTrace;

    typedef struct packed {
        logic                  we;
        logic [imAddrBits-1:0] addr; // word address
        logic [31:0]           data;
    } imLoad;

endpackage

// File: controller.sv
`timescale 1ns/10ps

module controller (
    input  mipsPkg::instrWord  instr,
    output mipsPkg::ctrlBundle ctrl
);

    import mipsPkg::*;

    always_comb begin
        // nop unless decoded below
        ctrl = '{npc: npcPc4, wr: wrRt, wd: wdAlu, ext: extZero, b: bReg, alu: aluAdd,
                 regWe: 1'b0, memWe: 1'b0, memSize: sizeWord, memSigned: 1'b0};
        case (instr.rType.op)
            opRType: begin
                ctrl.wr    = wrRd;
                ctrl.regWe = 1'b1;
                case (instr.rType.funct)
                    fnAddu: ctrl.alu = aluAdd;
                    fnSubu: ctrl.alu = aluSub;
                    fnAnd:  ctrl.alu = aluAnd;
                    fnOr:   ctrl.alu = aluOr;
                    fnSlt:  ctrl.alu = aluSlt;
                    fnSll:  ctrl.alu = aluSll;
                    fnSrl:  ctrl.alu = aluSrl;
                    fnJr: begin
                        ctrl.npc   = npcReg;
                        ctrl.regWe = 1'b0;
                    end
                    default: ctrl.regWe = 1'b0;
                endcase
            end
            opAddiu: begin
                ctrl.ext   = extSign;
                ctrl.b     = bImm;
                ctrl.regWe = 1'b1;
            end
            opOri: begin
                ctrl.b     = bImm;
                ctrl.alu   = aluOr;
                ctrl.regWe = 1'b1;
            end
            opLui: begin
                ctrl.ext   = extUpper;
                ctrl.b     = bImm;
                ctrl.alu   = aluLui;
                ctrl.regWe = 1'b1;
            end
            opLw, opLh, opLb, opLbu: begin
                ctrl.ext       = extSign;
                ctrl.b         = bImm;
                ctrl.wd        = wdMem;
                ctrl.regWe     = 1'b1;
                ctrl.memSigned = (instr.rType.op != opLbu);
                ctrl.memSize   = (instr.rType.op == opLw) ? sizeWord :
                                 (instr.rType.op == opLh) ? sizeHalf : sizeByte;
            end
            opSw, opSh, opSb: begin
                ctrl.ext     = extSign;
                ctrl.b       = bImm;
                ctrl.memWe   = 1'b1;
                ctrl.memSize = (instr.rType.op == opSw) ? sizeWord :
                               (instr.rType.op == opSh) ? sizeHalf : sizeByte;
            end
            opBeq: ctrl.npc = npcBeq;
            opBne: ctrl.npc = npcBne;
            opJ:   ctrl.npc = npcJump;
            opJal: begin
                ctrl.npc   = npcJump;
                ctrl.wr    = wrRa;
                ctrl.wd    = wdPc4;
                ctrl.regWe = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: pcUnit.sv
`timescale 1ns/10ps

module pcUnit (
    input  logic               clk,
    input  logic               arstN,
    input  mipsPkg::instrWord  instr,
    input  mipsPkg::ctrlBundle ctrl,
    input  logic               zero,
    input  logic [31:0]        ra,
    output logic [31:0]        pc,
    output logic [31:0]        pc4
);

    import mipsPkg::*;

    logic [31:0] brTarget, jTarget, npc;

    assign pc4      = pc + 32'd4;
    assign brTarget = pc4 + {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};
    assign jTarget  = {pc4[31:28], instr.jType.target, 2'b00}; // stays in the 256MB region

    always_comb begin
        case (ctrl.npc)
            npcBeq:  npc = zero ? brTarget : pc4;
            npcBne:  npc = zero ? pc4 : brTarget;
            npcJump: npc = jTarget;
            npcReg:  npc = ra;
            default: npc = pc4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) pc <= resetPc;
        else        pc <= npc;
    end

endmodule

// File: regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin // $0 stays zero
            regs[wa] <= wd;
        end
    end

    // reads see the old value until the commit edge
    assign rd1 = regs[rs];
    assign rd2 = regs[rt];

endmodule

// File: execUnit.sv
`timescale 1ns/10ps

module execUnit (
    input  mipsPkg::instrWord  instr,
    input  mipsPkg::ctrlBundle ctrl,
    input  logic [31:0]        rd1,
    input  logic [31:0]        rd2,
    output logic [31:0]        aluRes,
    output logic               zero
);

    import mipsPkg::*;

    logic [31:0] extImm, srcB;
    logic [4:0]  shamt;

    assign shamt = instr.rType.shamt;

    always_comb begin
        case (ctrl.ext)
            extSign:  extImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
            extUpper: extImm = {instr.iType.imm, 16'h0000};
            default:  extImm = {16'h0000, instr.iType.imm};
        endcase
    end

    assign srcB = (ctrl.b == bImm) ? extImm : rd2;

    always_comb begin
        case (ctrl.alu)
            aluAdd:  aluRes = rd1 + srcB;
            aluSub:  aluRes = rd1 - srcB;
            aluAnd:  aluRes = rd1 & srcB;
            aluOr:   aluRes = rd1 | srcB;
            aluSlt:  aluRes = {31'b0, $signed(rd1) < $signed(srcB)};
            aluSll:  aluRes = rd2 << shamt; // shifts act on rt
            aluSrl:  aluRes = rd2 >> shamt;
            aluLui:  aluRes = srcB;
            default: aluRes = '0;
        endcase
    end

    // branch compare works on the two registers, independent of the ALU op
    assign zero = (rd1 == rd2);

endmodule

// File: dataMem.sv
`timescale 1ns/10ps

module dataMem (
    input  logic               clk,
    input  logic               arstN,
    input  logic [31:0]        addr,
    input  logic [31:0]        wd,
    input  mipsPkg::ctrlBundle ctrl,
    output logic [31:0]        rdData
);

    import mipsPkg::*;

    logic [31:0]           mem [dmWords];
    logic [dmAddrBits-1:0] idx;
    logic [3:0]            be;
    logic [31:0]           wdLane, word;
    logic [15:0]           half;
    logic [7:0]            byteVal;

    assign idx = addr[dmAddrBits+1:2];

    // replicate store data so every lane carries it, then pick lanes by be
    always_comb begin
        case (ctrl.memSize)
            sizeByte: begin
                be     = 4'b0001 << addr[1:0];
                wdLane = {4{wd[7:0]}};
            end
            sizeHalf: begin
                be     = addr[1] ? 4'b1100 : 4'b0011;
                wdLane = {2{wd[15:0]}};
            end
            default: begin
                be     = 4'b1111;
                wdLane = wd;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmWords; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.memWe) begin
            for (int l = 0; l < 4; l++) begin
                if (be[l]) mem[idx][8*l +: 8] <= wdLane[8*l +: 8];
            end
        end
    end

    assign word    = mem[idx];
    assign half    = addr[1] ? word[31:16] : word[15:0];
    assign byteVal = word[8*addr[1:0] +: 8];

    always_comb begin
        case (ctrl.memSize)
            sizeByte: rdData = {{24{ctrl.memSigned & byteVal[7]}}, byteVal};
            sizeHalf: rdData = {{16{ctrl.memSigned & half[15]}}, half};
            default:  rdData = word;
        endcase
    end

endmodule

// File: instrMem.sv
`timescale 1ns/10ps

module instrMem (
    input  logic              clk,
    input  mipsPkg::imLoad    load,
    input  logic [31:0]       pc,
    output mipsPkg::instrWord instr
);

    import mipsPkg::*;

    logic [31:0] mem [imWords];

    always_ff @(posedge clk) begin
        if (load.we) mem[load.addr] <= load.data;
    end

    assign instr = mem[pc[imAddrBits+1:2]]; // word index, low pc bits ignored

endmodule

// File: mips.sv
`timescale 1ns/10ps

module mips (
    input  logic                clk,
    input  logic                arstN,
    input  mipsPkg::imLoad      load,
    output mipsPkg::commitTrace trace
);

    import mipsPkg::*;

    instrWord    instr;
    ctrlBundle   ctrl;
    logic [31:0] pc, pc4, rd1, rd2, aluRes, rdData, wdData;
    logic [4:0]  wa;
    logic        zero;

    pcUnit pcUnit_i (.clk(clk), .arstN(arstN), .instr(instr), .ctrl(ctrl), .zero(zero),
                     .ra(rd1), .pc(pc), .pc4(pc4));

    instrMem instrMem_i (.clk(clk), .load(load), .pc(pc), .instr(instr));

    controller controller_i (.instr(instr), .ctrl(ctrl));

    regFile regFile_i (.clk(clk), .arstN(arstN), .rs(instr.rType.rs), .rt(instr.rType.rt),
                       .wa(wa), .we(ctrl.regWe), .wd(wdData), .rd1(rd1), .rd2(rd2));

    execUnit execUnit_i (.instr(instr), .ctrl(ctrl), .rd1(rd1), .rd2(rd2),
                         .aluRes(aluRes), .zero(zero));

    dataMem dataMem_i (.clk(clk), .arstN(arstN), .addr(aluRes), .wd(rd2), .ctrl(ctrl),
                       .rdData(rdData));

    // write-back select
    assign wa = (ctrl.wr == wrRd) ? instr.rType.rd :
                (ctrl.wr == wrRa) ? 5'd31 : instr.rType.rt;

    assign wdData = (ctrl.wd == wdMem) ? rdData :
                    (ctrl.wd == wdPc4) ? pc4 : aluRes;

    // commit trace of the instruction retiring at the next edge
    assign trace.valid   = arstN;
    assign trace.pc      = pc;
    assign trace.regWe   = ctrl.regWe && (wa != 5'd0); // writes to $0 have no effect
    assign trace.regAddr = wa;
    assign trace.regData = wdData;

endmodule

// File: mips_properties.sv
`timescale 1ns/10ps

module mips_properties (
    input logic                clk,
    input logic                arstN,
    input logic [31:0]         pc,
    input logic [31:0]         rd1,
    input logic [31:0]         rd2,
    input mipsPkg::instrWord   instr,
    input mipsPkg::ctrlBundle  ctrl,
    input mipsPkg::commitTrace trace
);

    import mipsPkg::*;

    logic selfJump;

    // j or jal whose target is its own address
    assign selfJump = (ctrl.npc == npcJump) && ({pc[31:28], instr.jType.target, 2'b00} == pc);

    idleInReset: assert property (@(posedge clk) !arstN |-> !trace.valid && pc == resetPc)
        else $error("pc left its reset value or trace.valid went high during reset");

    // a write to $0 must never become visible on a read port
    zeroRegStaysZero: assert property (@(posedge clk) disable iff (!arstN)
        (instr.rType.rs != 5'd0 || rd1 == 32'd0) && (instr.rType.rt != 5'd0 || rd2 == 32'd0))
        else $error("register 0 read back nonzero data");

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc is not word-aligned");

    pcAdvances: assert property (@(posedge clk) disable iff (!arstN)
        trace.valid && trace.regWe && !selfJump |=> pc != $past(pc))
        else $error("pc did not move after a register write-back");

endmodule

bind mips mips_properties mips_properties_i (.clk(clk), .arstN(arstN), .pc(pc),
                                              .rd1(rd1), .rd2(rd2),
                                              .instr(instr), .ctrl(ctrl), .trace(trace));

// File: mipsTb.sv
`timescale 1ns/10ps

module mipsTb;

    import mipsPkg::*;

    logic       clk;
    logic       arstN;
    imLoad      load;
    commitTrace trace;

    logic [31:0] stim [0:255]; // count, program, trace length, expected trace
    int          instrCount;
    int          traceLen;
    int          watchCycles;

    mips mips_i (.clk(clk), .arstN(arstN), .load(load), .trace(trace));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Regression failed");
        $fatal(1, "commit trace mismatch");
    endtask

    task automatic checkTrace(input commitTrace act, input commitTrace exp);
        if (act.valid !== exp.valid) reportMismatch("trace.valid", 32'(act.valid), 32'(exp.valid));
        if (act.pc !== exp.pc) reportMismatch("trace.pc", act.pc, exp.pc);
        if (act.regWe !== exp.regWe) reportMismatch("trace.regWe", 32'(act.regWe), 32'(exp.regWe));
        if (exp.regWe) begin // address and data only matter for a write-back
            if (act.regAddr !== exp.regAddr)
                reportMismatch("trace.regAddr", 32'(act.regAddr), 32'(exp.regAddr));
            if (act.regData !== exp.regData)
                reportMismatch("trace.regData", act.regData, exp.regData);
        end
    endtask

    task automatic checkLoadIdle(input commitTrace act);
        if (act.valid !== 1'b0) reportMismatch("trace.valid", 32'(act.valid), 32'h0);
    endtask

    function automatic commitTrace expectedAt(input int k);
        commitTrace e;
        int         b;
        b         = instrCount + 2 + 4 * k;
        e.valid   = 1'b1;
        e.pc      = stim[b];
        e.regWe   = stim[b + 1][0];
        e.regAddr = stim[b + 2][4:0];
        e.regData = stim[b + 3];
        return e;
    endfunction

    initial begin
        arstN       = 1'b0;
        load        = '0;
        watchCycles = 0;
        $readmemh("mips_stim.txt", stim);
        instrCount = int'(stim[0]);
        traceLen   = int'(stim[instrCount + 1]);
        if (instrCount <= 0 || instrCount > imWords || traceLen <= 0 ||
            instrCount + 2 + 4 * traceLen > 256) begin
            $display("Stimulus file is missing or its counts do not fit the stimulus array");
            $display("Regression failed");
            $fatal(1, "bad stimulus file");
        end else begin
            watchCycles = instrCount + traceLen + 20;
            for (int i = 0; i < instrCount; i++) begin
                @(posedge clk);
                #1;
                load.we   = 1'b1;
                load.addr = i[imAddrBits-1:0];
                load.data = stim[i + 1];
                checkLoadIdle(trace);
            end
            // program is in, hold reset 4 more cycles
            for (int i = 0; i < 4; i++) begin
                @(posedge clk);
                #1;
                load = '0;
                checkLoadIdle(trace);
            end
            @(posedge clk);
            #1;
            arstN = 1'b1;
            for (int k = 0; k < traceLen; k++) begin
                @(negedge clk); // trace settles well before the commit edge
                checkTrace(trace, expectedAt(k));
            end
            $display("Regression passed");
            $finish;
        end
    end

    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk);
        $display("Watchdog expired: the commit trace did not finish within %0d cycles",
                 watchCycles);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

// File: mips_stim.txt
// word 0 instruction count, then one instruction word each, then the trace length
// each trace entry is pc regWe regAddr regData, two entries per line
20
2401FFFB 34028001 3C031234 00222021 00412823 00223024 00233825 0022402A
00024900 00015702 AC010000 A4020006 A0010009 8C0B0000 840C0006 800D0009
900E0007 24000005 00007821 10220005 142B0005 14220001 24100001 102B0001
24100001 0C00001D 0800001F 24100001 24100001 03E00008 24100001 0800001F
1C
00000000 1 01 FFFFFFFB  00000004 1 02 00008001
00000008 1 03 12340000  0000000C 1 04 00007FFC
00000010 1 05 00008006  00000014 1 06 00008001
00000018 1 07 FFFFFFFB  0000001C 1 08 00000001
00000020 1 09 00080010  00000024 1 0A 0000000F
00000028 0 00 00000000  0000002C 0 00 00000000
00000030 0 00 00000000  00000034 1 0B FFFFFFFB
00000038 1 0C FFFF8001  0000003C 1 0D FFFFFFFB
00000040 1 0E 00000080  00000044 0 00 00000000
00000048 1 0F 00000000  0000004C 0 00 00000000
00000050 0 00 00000000  00000054 0 00 00000000
0000005C 0 00 00000000  00000064 1 1F 00000068
00000074 0 00 00000000  00000068 0 00 00000000
0000007C 0 00 00000000  0000007C 0 00 00000000

// File: files.f
mipsPkg.sv
controller.sv
pcUnit.sv
regFile.sv
execUnit.sv
dataMem.sv
instrMem.sv
mips.sv
mips_properties.sv
mipsTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= mipsTb
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the regression, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
